//--- flist.f
hdl/bpu_pkg.sv
hdl/bu_res_if.sv
hdl/updown_counter.sv
hdl/ras.sv
hdl/btb.sv
hdl/next_pc_gen.sv
hdl/pc_predictor.sv
verif/pc_predictor_assert.sv
verif/tb_pc_predictor.sv

//--- hdl/bpu_pkg.sv
package bpu_pkg;

  // --------------------
  // Address space
  // --------------------

  // Width of every PC and target
  localparam int unsigned XLEN = 32;

  // Common address type
  typedef logic [XLEN-1:0] addr_t;

  // First PC out of reset
  localparam addr_t BOOT_ADDR = 32'h0000_1000;

  // --------------------
  // Branch target buffer
  // --------------------

  // Direct-mapped, one entry per index
  localparam int unsigned BTB_ENTRIES = 16;

  // Index from PC bits 5:2
  localparam int unsigned BTB_IDX_W = $clog2(BTB_ENTRIES);

  // Tag is everything above the index, PC bits 31:6
  localparam int unsigned BTB_TAG_W = XLEN - BTB_IDX_W - 2;

  // --------------------
  // Return address stack
  // --------------------

  // Number of buffered return addresses, power of two
  localparam int unsigned RAS_DEPTH = 4;

  // Control-flow kind stored in the BTB and reported by the branch unit
  typedef enum logic [1:0] {
    CF_BRANCH = 2'b00,
    CF_JUMP   = 2'b01,
    CF_CALL   = 2'b10,
    CF_RET    = 2'b11
  } cf_kind_e;

endpackage

//--- hdl/btb.sv
`timescale 1ns/1ps

module btb #(
  parameter int unsigned BTB_ENTRIES = bpu_pkg::BTB_ENTRIES
) (
  input  logic              clk_i,
  input  logic              rst_n_i,
  // Resolution from the branch unit
  bu_res_if.sink            res,
  // Lookup on the fetch PC
  input  bpu_pkg::addr_t    lookup_pc_i,
  output logic              hit_o,
  output bpu_pkg::addr_t    target_o,
  output bpu_pkg::cf_kind_e kind_o
);

  import bpu_pkg::*;

  // Index width follows the table size
  localparam int unsigned IdxW = $clog2(BTB_ENTRIES);
  // Tag takes over whatever bits the index gives up
  localparam int unsigned TagW = BTB_TAG_W + BTB_IDX_W - IdxW;

  // --------------------
  // Table storage
  // --------------------

  // Valid bits are control state, the rest is payload
  logic [BTB_ENTRIES-1:0] valid_q;
  logic [TagW-1:0]        tag_q    [BTB_ENTRIES];
  addr_t                  target_q [BTB_ENTRIES];
  cf_kind_e               kind_q   [BTB_ENTRIES];

  // Lookup fields
  logic [IdxW-1:0] lk_idx;
  logic [TagW-1:0] lk_tag;

  // Update fields
  logic [IdxW-1:0] up_idx;
  logic [TagW-1:0] up_tag;
  logic            up_alloc;
  logic            up_inval;

  // Word-aligned PC, index above the two low bits
  assign lk_idx = lookup_pc_i[IdxW+1:2];
  assign lk_tag = lookup_pc_i[XLEN-1:IdxW+2];

  assign up_idx = res.pc[IdxW+1:2];
  assign up_tag = res.pc[XLEN-1:IdxW+2];

  // --------------------
  // Update
  // --------------------

  // Any taken resolution allocates, no direction counters
  assign up_alloc = res.valid & res.taken;

  // A branch that fell through drops its entry, if it is really ours
  assign up_inval = res.valid & ~res.taken & (res.kind == CF_BRANCH)
                  & valid_q[up_idx] & (tag_q[up_idx] == up_tag);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q <= '0;
    end else if (up_alloc) begin
      valid_q[up_idx] <= 1'b1;
    end else if (up_inval) begin
      valid_q[up_idx] <= 1'b0;
    end
  end

  // Payload written on allocation only
  always_ff @(posedge clk_i) begin
    if (up_alloc) begin
      tag_q[up_idx]    <= up_tag;
      target_q[up_idx] <= res.target;
      kind_q[up_idx]   <= res.kind;
    end
  end

  // --------------------
  // Lookup
  // --------------------

  // Combinational read, same-cycle updates not visible yet
  assign hit_o    = valid_q[lk_idx] & (tag_q[lk_idx] == lk_tag);
  assign target_o = target_q[lk_idx];
  assign kind_o   = kind_q[lk_idx];

endmodule

//--- hdl/bu_res_if.sv
`timescale 1ns/1ps

interface bu_res_if;

  import bpu_pkg::*;

  // One resolution from the branch unit, a single-cycle strobe on valid
  logic     valid;
  addr_t    pc;
  addr_t    target;
  cf_kind_e kind;
  logic     taken;
  // Only ever set together with valid
  logic     mispredict;

  // Branch unit side
  modport driver (
    output valid, pc, target, kind, taken, mispredict
  );

  // BTB and PC generator side
  modport sink (
    input valid, pc, target, kind, taken, mispredict
  );

endinterface

//--- hdl/next_pc_gen.sv
`timescale 1ns/1ps

module next_pc_gen (
  input  logic              clk_i,
  input  logic              rst_n_i,
  // Fetch strobe, low holds the PC
  input  logic              fetch_ready_i,
  // Resolution from the branch unit
  bu_res_if.sink            res,
  // BTB lookup on the current PC
  input  logic              btb_hit_i,
  input  bpu_pkg::addr_t    btb_target_i,
  input  bpu_pkg::cf_kind_e btb_kind_i,
  // RAS interface
  input  bpu_pkg::addr_t    ras_top_i,
  output logic              ras_push_o,
  output logic              ras_pop_o,
  output bpu_pkg::addr_t    ras_ret_addr_o,
  // Fetch PC
  output bpu_pkg::addr_t    pc_o
);

  import bpu_pkg::*;

  // Fall-through of the current PC and of the resolved instruction
  addr_t pc_seq;
  addr_t res_seq;

  // Candidate next PCs
  addr_t pred_pc;
  addr_t fix_pc;
  addr_t pc_d;

  logic redirect;

  assign pc_seq  = pc_o + 32'd4;
  assign res_seq = res.pc + 32'd4;

  // --------------------
  // RAS control
  // --------------------

  // Calls push their link address, returns pop
  assign ras_push_o     = res.valid & (res.kind == CF_CALL);
  assign ras_pop_o      = res.valid & (res.kind == CF_RET);
  assign ras_ret_addr_o = res_seq;

  // --------------------
  // Next PC selection
  // --------------------

  // Prediction, return over BTB target over sequential
  always_comb begin
    if (btb_hit_i && (btb_kind_i == CF_RET)) pred_pc = ras_top_i;
    else if (btb_hit_i)                      pred_pc = btb_target_i;
    else                                     pred_pc = pc_seq;
  end

  // Correct path after a wrong guess
  assign fix_pc   = res.taken ? res.target : res_seq;
  assign redirect = res.valid & res.mispredict;

  // Redirect wins even with a fetch in the same cycle
  always_comb begin
    if (redirect)           pc_d = fix_pc;
    else if (fetch_ready_i) pc_d = pred_pc;
    else                    pc_d = pc_o;
  end

  // PC register
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pc_o <= BOOT_ADDR;
    end else begin
      pc_o <= pc_d;
    end
  end

endmodule

//--- hdl/pc_predictor.sv
`timescale 1ns/1ps

module pc_predictor (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              fetch_ready_i,
  // Branch unit resolution
  input  logic              res_valid_i,
  input  bpu_pkg::addr_t    res_pc_i,
  input  bpu_pkg::addr_t    res_target_i,
  input  bpu_pkg::cf_kind_e res_kind_i,
  input  logic              res_taken_i,
  input  logic              res_mispredict_i,
  // Prediction outputs
  output bpu_pkg::addr_t    pc_o,
  output logic              pred_hit_o,
  output bpu_pkg::cf_kind_e pred_kind_o
);

  import bpu_pkg::*;

  // BTB lookup results
  logic     btb_hit;
  addr_t    btb_target;
  cf_kind_e btb_kind;

  // RAS traffic
  logic  ras_push;
  logic  ras_pop;
  addr_t ras_ret_addr;
  addr_t ras_top;

  // --------------------
  // Resolution bundle
  // --------------------

  bu_res_if u_res_if ();

  assign u_res_if.valid      = res_valid_i;
  assign u_res_if.pc         = res_pc_i;
  assign u_res_if.target     = res_target_i;
  assign u_res_if.kind       = res_kind_i;
  assign u_res_if.taken      = res_taken_i;
  assign u_res_if.mispredict = res_mispredict_i;

  // --------------------
  // Blocks
  // --------------------

  btb #(
    .BTB_ENTRIES(BTB_ENTRIES)
  ) u_btb (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .res        (u_res_if.sink),
    .lookup_pc_i(pc_o),
    .hit_o      (btb_hit),
    .target_o   (btb_target),
    .kind_o     (btb_kind)
  );

  ras #(
    .RAS_DEPTH(RAS_DEPTH)
  ) u_ras (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .push_i    (ras_push),
    .pop_i     (ras_pop),
    .ret_addr_i(ras_ret_addr),
    .ret_addr_o(ras_top)
  );

  next_pc_gen u_next_pc_gen (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .fetch_ready_i (fetch_ready_i),
    .res           (u_res_if.sink),
    .btb_hit_i     (btb_hit),
    .btb_target_i  (btb_target),
    .btb_kind_i    (btb_kind),
    .ras_top_i     (ras_top),
    .ras_push_o    (ras_push),
    .ras_pop_o     (ras_pop),
    .ras_ret_addr_o(ras_ret_addr),
    .pc_o          (pc_o)
  );

  // Prediction seen by fetch for the current PC
  assign pred_hit_o  = btb_hit;
  assign pred_kind_o = btb_kind;

endmodule

//--- hdl/ras.sv
`timescale 1ns/1ps

module ras #(
  // Must be a power of two so the index wraps with the counter
  parameter int unsigned RAS_DEPTH = bpu_pkg::RAS_DEPTH
) (
  input  logic           clk_i,
  input  logic           rst_n_i,
  // From the PC generator
  input  logic           push_i,
  input  logic           pop_i,
  input  bpu_pkg::addr_t ret_addr_i,
  output bpu_pkg::addr_t ret_addr_o
);

  import bpu_pkg::*;

  localparam int unsigned IdxW = (RAS_DEPTH > 1) ? $clog2(RAS_DEPTH) : 1;

  // Circular storage of return addresses
  addr_t ras_q [RAS_DEPTH];

  // Next free slot, top entry and the slot being written
  logic            cnt_en;
  logic [IdxW-1:0] new_idx;
  logic [IdxW-1:0] last_idx;
  logic [IdxW-1:0] wr_idx;

  // --------------------
  // Slot pointer
  // --------------------

  // Steps only on a lone push or a lone pop
  assign cnt_en = push_i ^ pop_i;

  updown_counter #(
    .W(IdxW)
  ) u_new_cnt (
    .clk_i  (clk_i),
    .rst_n_i(rst_n_i),
    .en_i   (cnt_en),
    .clr_i  (1'b0),
    .up_dn_i(push_i),
    .count_o(new_idx),
    .tc_o   ()
  );

  assign last_idx = new_idx - 1'b1;

  // --------------------
  // LIFO storage
  // --------------------

  // Push with pop replaces the top, a lone push fills the free slot
  // Overflow simply overwrites the oldest entry
  assign wr_idx = pop_i ? last_idx : new_idx;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      foreach (ras_q[i]) ras_q[i] <= '0;
    end else if (push_i) begin
      ras_q[wr_idx] <= ret_addr_i;
    end
  end

  // Top of stack is the entry below the free slot
  assign ret_addr_o = ras_q[last_idx];

endmodule

//--- hdl/updown_counter.sv
`timescale 1ns/1ps

module updown_counter #(
  parameter int unsigned W = $clog2(bpu_pkg::RAS_DEPTH)
) (
  input  logic         clk_i,
  input  logic         rst_n_i,
  input  logic         en_i,
  input  logic         clr_i,
  input  logic         up_dn_i,
  output logic [W-1:0] count_o,
  output logic         tc_o
);

  // --------------------
  // Counter register
  // --------------------

  // Clear wins over enable, wraps modulo 2^W
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      count_o <= '0;
    end else if (clr_i) begin
      count_o <= '0;
    end else if (en_i) begin
      if (up_dn_i) count_o <= count_o + 1'b1;
      else         count_o <= count_o - 1'b1;
    end
  end

  // Terminal count depends on direction
  // All ones going up, zero going down
  assign tc_o = up_dn_i ? (&count_o) : ~(|count_o);

endmodule

//--- verif/pc_predictor_assert.sv
`timescale 1ns/1ps

module pc_predictor_assert (
  input logic           clk_i,
  input logic           rst_n_i,
  input logic           fetch_ready_i,
  input logic           res_valid_i,
  input logic           res_mispredict_i,
  input logic           ras_push_i,
  input bpu_pkg::addr_t ras_ret_addr_i,
  input bpu_pkg::addr_t ras_top_i,
  input bpu_pkg::addr_t pc_i
);

  // Failed assertions so far, polled by the testbench
  int unsigned fail_count;

  initial fail_count = 0;

  // --------------------
  // RAS and resolution
  // --------------------

  // A pushed link address is the RAS top one cycle later, also when it replaces the top
  push_top_a : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    ras_push_i |=> (ras_top_i == $past(ras_ret_addr_i))
  ) else begin
    $error("RAS top is not the address pushed in the previous cycle");
    fail_count++;
  end

  // A mispredict never arrives on its own
  mispredict_valid_a : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    res_mispredict_i |-> res_valid_i
  ) else begin
    $error("Mispredict seen without a valid resolution");
    fail_count++;
  end

  // --------------------
  // PC register
  // --------------------

  // Fetch is word based without compressed instructions
  pc_aligned_a : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    pc_i[1:0] == 2'b00
  ) else begin
    $error("PC lost its word alignment");
    fail_count++;
  end

  // Back-pressure with no redirect freezes the PC
  pc_hold_a : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    (!fetch_ready_i && !res_mispredict_i) |=> (pc_i == $past(pc_i))
  ) else begin
    $error("PC moved without a fetch strobe or a redirect");
    fail_count++;
  end

endmodule

// One checker per PC generator
bind next_pc_gen pc_predictor_assert u_pc_assert (
  .clk_i           (clk_i),
  .rst_n_i         (rst_n_i),
  .fetch_ready_i   (fetch_ready_i),
  .res_valid_i     (res.valid),
  .res_mispredict_i(res.mispredict),
  .ras_push_i      (ras_push_o),
  .ras_ret_addr_i  (ras_ret_addr_o),
  .ras_top_i       (ras_top_i),
  .pc_i            (pc_o)
);

//--- verif/pc_predictor_patterns.txt
# fetch_ready res_valid res_pc res_target res_kind res_taken res_mispredict exp_pc exp_hit exp_kind
# All hex, kind 0 branch 1 jump 2 call 3 ret, exp_kind is checked only when exp_hit is 1
# Sequential fetch, holds while fetch_ready is low
1 0 00000000 00000000 0 0 0 00001000 0 0
1 0 00000000 00000000 0 0 0 00001004 0 0
0 0 00000000 00000000 0 0 0 00001008 0 0
0 0 00000000 00000000 0 0 0 00001008 0 0
1 0 00000000 00000000 0 0 0 00001008 0 0
1 0 00000000 00000000 0 0 0 0000100c 0 0
# Taken jump at 1018 allocates, the hit then loads 2000
1 1 00001018 00002000 1 1 0 00001010 0 0
1 0 00000000 00000000 0 0 0 00001014 0 0
0 0 00000000 00000000 0 0 0 00001018 1 1
1 0 00000000 00000000 0 0 0 00001018 1 1
1 0 00000000 00000000 0 0 0 00002000 0 0
1 0 00000000 00000000 0 0 0 00002004 0 0
# Mispredict redirects, taken and not taken, with and without fetch
1 1 00003000 00004000 0 1 1 00002008 0 0
1 0 00000000 00000000 0 0 0 00004000 0 0
1 1 00003ff0 00005000 0 0 1 00004004 0 0
1 0 00000000 00000000 0 0 0 00003ff4 0 0
0 1 00003ff8 00001018 1 1 1 00003ff8 0 0
1 0 00000000 00000000 0 0 0 00001018 1 1
1 0 00000000 00000000 0 0 0 00002000 0 0
# Return entry at 8010, three nested calls, returns come back in LIFO order
0 1 00008010 00005024 3 1 0 00002004 0 0
0 1 00005020 00006024 2 1 0 00002004 0 0
0 1 00006024 00007028 2 1 0 00002004 0 0
0 1 00007028 00008000 2 1 0 00002004 0 0
0 1 0000800c 00000000 0 0 1 00002004 0 0
1 0 00000000 00000000 0 0 0 00008010 1 3
0 1 00008010 0000702c 3 1 0 0000702c 0 0
0 1 0000800c 00000000 0 0 1 0000702c 0 0
1 0 00000000 00000000 0 0 0 00008010 1 3
0 1 00008010 00006028 3 1 0 00006028 0 0
0 1 0000800c 00000000 0 0 1 00006028 0 0
1 0 00000000 00000000 0 0 0 00008010 1 3
1 0 00000000 00000000 0 0 0 00005024 0 0
# Not-taken branch at 1030 drops its entry, fetch falls back to plus 4
0 1 00001030 00009000 0 1 0 00005028 0 0
0 1 0000102c 00000000 0 0 1 00005028 0 0
0 0 00000000 00000000 0 0 0 00001030 1 0
0 1 00001030 00009000 0 0 0 00001030 1 0
1 0 00000000 00000000 0 0 0 00001030 0 0
1 0 00000000 00000000 0 0 0 00001034 0 0
# Five calls wrap the stack, a004 is overwritten by a404
0 1 0000a000 0000b000 2 1 0 00001038 0 0
0 1 0000a100 0000b000 2 1 0 00001038 0 0
0 1 0000a200 0000b000 2 1 0 00001038 0 0
0 1 0000a300 0000b000 2 1 0 00001038 0 0
0 1 0000a400 0000b000 2 1 0 00001038 0 0
0 1 0000800c 00000000 0 0 1 00001038 0 0
1 0 00000000 00000000 0 0 0 00008010 1 3
1 1 00008010 00008010 3 1 1 0000a404 0 0
1 0 00000000 00000000 0 0 0 00008010 1 3
1 1 00008010 00008010 3 1 1 0000a304 0 0
1 0 00000000 00000000 0 0 0 00008010 1 3
1 1 00008010 00008010 3 1 1 0000a204 0 0
1 0 00000000 00000000 0 0 0 00008010 1 3
1 1 00008010 00008010 3 1 1 0000a104 0 0
1 0 00000000 00000000 0 0 0 00008010 1 3
1 0 00000000 00000000 0 0 0 0000a404 0 0
1 0 00000000 00000000 0 0 0 0000a408 0 0
# Call entry at a400 hits and loads its target
0 1 0000a3fc 00000000 0 0 1 0000a40c 0 0
1 0 00000000 00000000 0 0 0 0000a400 1 2
1 0 00000000 00000000 0 0 0 0000b000 0 0
0 0 00000000 00000000 0 0 0 0000b004 0 0

//--- verif/tb_pc_predictor.sv
`timescale 1ns/1ps

module tb_pc_predictor;

  import bpu_pkg::*;

  // --------------------
  // Run setup
  // --------------------

  localparam time   CLK_PERIOD   = 100ns;
  // Outputs read 10 ns ahead of the next rising edge
  localparam time   SAMPLE_DELAY = 90ns;
  localparam int    RST_CYCLES   = 10;
  localparam int    SLACK_CYCLES = 20;
  localparam string PATTERN_FILE = "verif/pc_predictor_patterns.txt";

  // One line of the pattern file holds inputs then expected outputs
  typedef struct {
    logic     fetch_ready;
    logic     res_valid;
    addr_t    res_pc;
    addr_t    res_target;
    cf_kind_e res_kind;
    logic     res_taken;
    logic     res_mispredict;
    addr_t    exp_pc;
    logic     exp_hit;
    cf_kind_e exp_kind;
  } pattern_t;

  logic     clk_i;
  logic     rst_n_i;
  logic     fetch_ready_i;
  logic     res_valid_i;
  addr_t    res_pc_i;
  addr_t    res_target_i;
  cf_kind_e res_kind_i;
  logic     res_taken_i;
  logic     res_mispredict_i;
  addr_t    pc_o;
  logic     pred_hit_o;
  cf_kind_e pred_kind_o;

  pattern_t patterns [$];
  logic     patterns_loaded = 1'b0;

  pc_predictor dut_i (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .fetch_ready_i   (fetch_ready_i),
    .res_valid_i     (res_valid_i),
    .res_pc_i        (res_pc_i),
    .res_target_i    (res_target_i),
    .res_kind_i      (res_kind_i),
    .res_taken_i     (res_taken_i),
    .res_mispredict_i(res_mispredict_i),
    .pc_o            (pc_o),
    .pred_hit_o      (pred_hit_o),
    .pred_kind_o     (pred_kind_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  // --------------------
  // Helpers
  // --------------------

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Test failed");
    $fatal(1, "Simulation stopped at the first failure");
  endtask

  task automatic check_pc(input addr_t expected, input addr_t actual, input string name);
    if (actual !== expected) begin
      abort_run($sformatf("ERROR at %0d ns: %s expected %h, got %h",
                          $time, name, expected, actual));
    end
  endtask

  task automatic check_hit(input logic expected, input logic actual, input string name);
    if (actual !== expected) begin
      abort_run($sformatf("ERROR at %0d ns: %s expected %b, got %b",
                          $time, name, expected, actual));
    end
  endtask

  task automatic check_kind(input cf_kind_e expected, input cf_kind_e actual,
                            input string name);
    if (actual !== expected) begin
      abort_run($sformatf("ERROR at %0d ns: %s expected %s, got %s (%b)",
                          $time, name, expected.name(), actual.name(), actual));
    end
  endtask

  // Count kept by the bound checker in the PC generator
  function automatic int assert_failures();
    return dut_i.u_next_pc_gen.u_pc_assert.fail_count;
  endfunction

  // Blank lines and lines starting with # carry no pattern
  function automatic bit is_data_line(input string s);
    int i;
    i = 0;
    while (i < s.len() && (s[i] == " " || s[i] == "\t")) i++;
    if (i >= s.len()) return 1'b0;
    return !(s[i] == "#" || s[i] == "\n" || s[i] == "\r");
  endfunction

  task automatic read_patterns();
    int          fd;
    int          n;
    string       line;
    logic [31:0] f [10];
    pattern_t    p;
    fd = $fopen(PATTERN_FILE, "r");
    if (fd == 0) begin
      abort_run({"Pattern file ", PATTERN_FILE, " is missing or cannot be read"});
    end else begin
      while ($fgets(line, fd) != 0) begin
        if (is_data_line(line)) begin
          n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h",
                      f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9]);
          if (n != 10) begin
            abort_run({"Pattern line does not hold ten fields: ", line});
          end else begin
            p.fetch_ready    = f[0][0];
            p.res_valid      = f[1][0];
            p.res_pc         = f[2];
            p.res_target     = f[3];
            p.res_kind       = cf_kind_e'(f[4][1:0]);
            p.res_taken      = f[5][0];
            p.res_mispredict = f[6][0];
            p.exp_pc         = f[7];
            p.exp_hit        = f[8][0];
            p.exp_kind       = cf_kind_e'(f[9][1:0]);
            patterns.push_back(p);
          end
        end
      end
      $fclose(fd);
      if (patterns.size() == 0) abort_run("Pattern file holds no pattern lines");
    end
  endtask

  task automatic drive_inputs(input pattern_t p);
    fetch_ready_i    <= p.fetch_ready;
    res_valid_i      <= p.res_valid;
    res_pc_i         <= p.res_pc;
    res_target_i     <= p.res_target;
    res_kind_i       <= p.res_kind;
    res_taken_i      <= p.res_taken;
    res_mispredict_i <= p.res_mispredict;
  endtask

  // --------------------
  // Stimulus and checks
  // --------------------

  initial begin : stimulus
    rst_n_i          = 1'b0;
    fetch_ready_i    = 1'b0;
    res_valid_i      = 1'b0;
    res_pc_i         = '0;
    res_target_i     = '0;
    res_kind_i       = CF_BRANCH;
    res_taken_i      = 1'b0;
    res_mispredict_i = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_i);
    rst_n_i <= 1'b1;
    read_patterns();
    patterns_loaded = 1'b1;
    foreach (patterns[i]) begin
      @(posedge clk_i);
      drive_inputs(patterns[i]);
      #(SAMPLE_DELAY);
      check_pc(patterns[i].exp_pc, pc_o, "pc_o");
      check_hit(patterns[i].exp_hit, pred_hit_o, "pred_hit_o");
      // Kind is entry payload and only meaningful on a hit
      if (patterns[i].exp_hit) check_kind(patterns[i].exp_kind, pred_kind_o, "pred_kind_o");
      if (assert_failures() != 0) abort_run("An assertion in next_pc_gen failed");
    end
    // Let the last pattern reach the assertions, including the next-cycle ones
    repeat (2) @(posedge clk_i);
    #(SAMPLE_DELAY);
    if (assert_failures() != 0) begin
      abort_run("An assertion in next_pc_gen failed");
    end else begin
      $display("Test passed");
      $finish;
    end
  end

  // Budget grows with the pattern count
  initial begin : watchdog
    wait (patterns_loaded === 1'b1);
    #((patterns.size() + SLACK_CYCLES) * CLK_PERIOD);
    abort_run("Watchdog expired before the pattern run completed");
  end

endmodule
